// ==== hdl/div_pkg.sv ====
`default_nettype none

package div_pkg;

    // Operand and result width
    localparam int DATA_W     = 32;

    // Lane array
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    // One load cycle plus one cycle per quotient bit
    localparam int ITER_CNT   = DATA_W + 1;
    localparam int CNT_W      = $clog2(ITER_CNT);

endpackage

`default_nettype wire

// ==== hdl/apb_map_pkg.sv ====
`default_nettype none

package apb_map_pkg;

    localparam int ADDR_W = 8;

    // Each lane owns one block of registers
    localparam logic [ADDR_W-1:0] LANE_STRIDE     = 8'h20;

    localparam logic [ADDR_W-1:0] OFS_DIVIDEND    = 8'h00;
    localparam logic [ADDR_W-1:0] OFS_DIVISOR     = 8'h04;
    localparam logic [ADDR_W-1:0] OFS_CTRL_STATUS = 8'h08;
    localparam logic [ADDR_W-1:0] OFS_QUOTIENT    = 8'h0C;
    localparam logic [ADDR_W-1:0] OFS_REMAINDER   = 8'h10;

    // Command view, as written
    typedef struct packed {
        logic [28:0] reserved;
        logic        cancel;
        logic        signed_op;
        logic        start;
    } ctrl_word_t;

    // Status view, as read
    typedef struct packed {
        logic [27:0] zero;
        logic        signed_mode;
        logic        div_by_zero;
        logic        done;
        logic        busy;
    } status_word_t;

    typedef union packed {
        ctrl_word_t   ctrl;
        status_word_t status;
    } ctrl_status_u;

endpackage

`default_nettype wire

// ==== hdl/div_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Request path, issue block to lane
interface div_req_if import div_pkg::*; ();
    logic              valid;
    logic              ready;
    logic              signed_op;
    logic              cancel;
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;

    modport issuer (output valid, signed_op, cancel, dividend, divisor, input ready);
    modport lane (input valid, signed_op, cancel, dividend, divisor, output ready);
endinterface

// Result path, lane to collector
interface div_rsp_if import div_pkg::*; ();
    logic              valid;
    logic              busy;
    logic              div_by_zero;
    // Mode of the operation that produced the result
    logic              signed_op;
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;

    modport lane (
        output valid, busy, div_by_zero, signed_op, quotient, remainder
    );
    modport collector (
        input  valid, busy, div_by_zero, signed_op, quotient, remainder
    );
endinterface

`default_nettype wire

// ==== hdl/apb_div_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_div_issue import div_pkg::*, apb_map_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic              pslverr_o,
    div_req_if.issuer         req [NUM_LANES]
);

    logic [ADDR_W-1:0]     lane_sel;
    logic [LANE_IDX_W-1:0] lane_idx;
    logic [ADDR_W-1:0]     ofs;
    logic                  wr_acc;
    logic                  ctrl_wr;
    ctrl_status_u          cmd;
    logic [NUM_LANES-1:0]  lane_busy;

    // Address decode
    assign lane_sel = paddr_i / LANE_STRIDE;
    assign lane_idx = lane_sel[LANE_IDX_W-1:0];
    assign ofs      = paddr_i % LANE_STRIDE;
    assign wr_acc   = psel_i && penable_i && pwrite_i && (lane_sel < ADDR_W'(NUM_LANES));
    assign ctrl_wr  = wr_acc && (ofs == OFS_CTRL_STATUS);
    assign cmd      = pwdata_i;

    // Start to a lane that is still working
    assign pslverr_o = ctrl_wr && cmd.ctrl.start && lane_busy[lane_idx];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic              sel;
        logic              start_ok;
        logic              valid_q;
        logic              cancel_q;
        logic              signed_q;
        logic [DATA_W-1:0] dividend_q;
        logic [DATA_W-1:0] divisor_q;

        assign sel      = (lane_idx == LANE_IDX_W'(i));
        assign start_ok = ctrl_wr && sel && cmd.ctrl.start && !lane_busy[i];
        // A start still waiting for the lane counts as busy
        assign lane_busy[i] = valid_q || !req[i].ready;

        always_ff @(posedge clk) begin
            if (wr_acc && sel && (ofs == OFS_DIVIDEND)) begin
                dividend_q <= pwdata_i;
            end
            if (wr_acc && sel && (ofs == OFS_DIVISOR)) begin
                divisor_q <= pwdata_i;
            end
            if (start_ok) begin
                signed_q <= cmd.ctrl.signed_op;
            end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                valid_q  <= 1'b0;
                cancel_q <= 1'b0;
            end else begin
                cancel_q <= ctrl_wr && sel && cmd.ctrl.cancel;
                if (start_ok) begin
                    valid_q <= 1'b1;
                end else if (req[i].ready) begin
                    valid_q <= 1'b0;
                end
            end
        end

        assign req[i].valid     = valid_q;
        assign req[i].cancel    = cancel_q;
        assign req[i].signed_op = signed_q;
        assign req[i].dividend  = dividend_q;
        assign req[i].divisor   = divisor_q;
    end

    // ------------------------------
    // Errors only at the end of a proper setup/access pair
    a_err_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        pslverr_o |-> penable_i && $past(psel_i && !penable_i));

endmodule

`default_nettype wire

// ==== hdl/div_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_lane import div_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    div_req_if.lane req,
    div_rsp_if.lane rsp
);

    // Control
    logic              busy_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              hs;
    logic              load;
    logic              last_step;

    // Datapath
    logic              signed_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              dbz_q;
    logic [DATA_W-1:0] quo_q;
    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] dvs_q;
    logic              dvd_neg;
    logic              dvs_neg;
    logic [DATA_W-1:0] dvd_abs;
    logic [DATA_W-1:0] dvs_abs;
    logic [DATA_W:0]   rem_sh;
    logic [DATA_W+1:0] diff;
    logic              fits;
    logic [DATA_W-1:0] quo_nxt;
    logic [DATA_W-1:0] rem_nxt;

    assign req.ready = !busy_q;
    assign hs        = req.valid && req.ready;
    assign load      = busy_q && (cnt_q == '0);
    assign last_step = busy_q && (cnt_q == CNT_W'(ITER_CNT - 1));

    // Raw operands sit in quo_q and dvs_q until the load cycle
    assign dvd_neg = signed_q && quo_q[DATA_W-1];
    assign dvs_neg = signed_q && dvs_q[DATA_W-1];
    assign dvd_abs = dvd_neg ? -quo_q : quo_q;
    assign dvs_abs = dvs_neg ? -dvs_q : dvs_q;

    // ------------------------------
    // One restoring step
    // ------------------------------
    assign rem_sh  = {rem_q, quo_q[DATA_W-1]};
    assign diff    = {1'b0, rem_sh} - {2'b00, dvs_q};
    assign fits    = !diff[DATA_W+1];
    assign rem_nxt = fits ? diff[DATA_W-1:0] : rem_sh[DATA_W-1:0];
    assign quo_nxt = {quo_q[DATA_W-2:0], fits};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q && req.cancel) begin
            busy_q <= 1'b0;
        end else if (hs) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            busy_q <= !last_step;
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hs) begin
            quo_q    <= req.dividend;
            dvs_q    <= req.divisor;
            signed_q <= req.signed_op;
        end else if (load) begin
            quo_q   <= dvd_abs;
            dvs_q   <= dvs_abs;
            rem_q   <= '0;
            dbz_q   <= (dvs_q == '0);
            r_neg_q <= dvd_neg;
            // Zero divisor keeps the all-ones quotient unsigned
            q_neg_q <= (dvd_neg ^ dvs_neg) && (dvs_q != '0);
        end else if (busy_q) begin
            quo_q <= quo_nxt;
            rem_q <= rem_nxt;
        end
    end

    // Result leaves with the last step, stored by the collector on the same edge
    assign rsp.valid       = last_step && !req.cancel;
    assign rsp.busy        = busy_q;
    assign rsp.quotient    = q_neg_q ? -quo_nxt : quo_nxt;
    assign rsp.remainder   = r_neg_q ? -rem_nxt : rem_nxt;
    assign rsp.div_by_zero = dbz_q;
    assign rsp.signed_op   = signed_q;

    // ------------------------------
    a_no_hs_busy: assert property (@(posedge clk) disable iff (!rst_n_i || req.cancel)
        hs |=> (!hs) [*ITER_CNT]);

    a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp.valid |-> $past(hs, ITER_CNT));

endmodule

`default_nettype wire

// ==== hdl/div_result_collect.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_result_collect import div_pkg::*, apb_map_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    div_rsp_if.collector      rsp [NUM_LANES]
);

    logic [ADDR_W-1:0]     lane_sel;
    logic [LANE_IDX_W-1:0] lane_idx;
    logic [ADDR_W-1:0]     ofs;
    logic                  rd_acc;
    logic                  res_rd;
    ctrl_status_u          stat;

    // Per-lane result store
    logic [DATA_W-1:0]     quo_q [NUM_LANES];
    logic [DATA_W-1:0]     rem_q [NUM_LANES];
    logic [NUM_LANES-1:0]  done_q;
    logic [NUM_LANES-1:0]  dbz_q;
    logic [NUM_LANES-1:0]  sgn_q;
    logic [NUM_LANES-1:0]  busy;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign busy[i] = rsp[i].busy;

        always_ff @(posedge clk) begin
            if (rsp[i].valid) begin
                quo_q[i] <= rsp[i].quotient;
                rem_q[i] <= rsp[i].remainder;
            end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                done_q[i] <= 1'b0;
                dbz_q[i]  <= 1'b0;
                sgn_q[i]  <= 1'b0;
            end else if (rsp[i].valid) begin
                done_q[i] <= 1'b1;
                dbz_q[i]  <= rsp[i].div_by_zero;
                sgn_q[i]  <= rsp[i].signed_op;
            end else if (rsp[i].busy) begin
                // New operation under way
                done_q[i] <= 1'b0;
                dbz_q[i]  <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------
    assign lane_sel = paddr_i / LANE_STRIDE;
    assign lane_idx = lane_sel[LANE_IDX_W-1:0];
    assign ofs      = paddr_i % LANE_STRIDE;
    assign rd_acc   = psel_i && penable_i && !pwrite_i && (lane_sel < ADDR_W'(NUM_LANES));
    assign res_rd   = (ofs == OFS_QUOTIENT) || (ofs == OFS_REMAINDER);

    // Result reads wait for a busy lane
    assign pready_o = psel_i && penable_i && !(rd_acc && res_rd && busy[lane_idx]);

    always_comb begin
        stat                    = '0;
        stat.status.busy        = busy[lane_idx];
        stat.status.done        = done_q[lane_idx];
        stat.status.div_by_zero = dbz_q[lane_idx];
        stat.status.signed_mode = sgn_q[lane_idx];
    end

    always_comb begin
        prdata_o = '0;
        if (rd_acc) begin
            case (ofs)
                OFS_CTRL_STATUS: prdata_o = stat;
                OFS_QUOTIENT:    prdata_o = quo_q[lane_idx];
                OFS_REMAINDER:   prdata_o = rem_q[lane_idx];
                default:         prdata_o = '0;
            endcase
        end
    end

    // A stalled read must stay on the bus unchanged
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (psel_i && penable_i && !pready_o) |=> psel_i && penable_i && $stable(paddr_i));

endmodule

`default_nettype wire

// ==== hdl/div_array_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_array_top import div_pkg::*, apb_map_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    // APB slave
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] pwdata_i,
    output logic [DATA_W-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o
);

    div_req_if req_if [NUM_LANES] ();
    div_rsp_if rsp_if [NUM_LANES] ();

    apb_div_issue u_issue (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pslverr_o (pslverr_o),
        .req       (req_if)
    );

    // Divider lanes
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane u_lane (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .req     (req_if[i]),
            .rsp     (rsp_if[i])
        );
    end

    div_result_collect u_collect (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .rsp       (rsp_if)
    );

endmodule

`default_nettype wire

// ==== dv/div_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_checker import div_pkg::*, apb_map_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  logic [DATA_W-1:0] prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i
);

    // One entry per APB transfer, in bus order
    typedef struct {
        string             name;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] mask;
        logic              err;
    } xfer_exp_t;

    xfer_exp_t exp_q [$];
    int        data_errors = 0;
    int        resp_errors = 0;

    // Mask of zero skips the data compare
    task automatic expect_xfer(input string name, input logic [DATA_W-1:0] data,
                               input logic [DATA_W-1:0] mask, input logic err);
        xfer_exp_t e;
        e.name = name;
        e.data = data;
        e.mask = mask;
        e.err  = err;
        exp_q.push_back(e);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // ------------------------------
    // Compare at each completed transfer
    always @(posedge clk) begin : monitor
        xfer_exp_t e;
        if (rst_n_i && psel_i && penable_i && pready_i) begin
            if (exp_q.size() == 0) begin
                $display("error: transfer to address %h completed with nothing expected",
                         paddr_i);
                resp_errors++;
            end else begin
                e = exp_q.pop_front();
                if (!pwrite_i && ((prdata_i & e.mask) !== (e.data & e.mask))) begin
                    $display("mismatch test %s addr %h: expected %h, actual %h",
                             e.name, paddr_i, e.data & e.mask, prdata_i & e.mask);
                    data_errors++;
                end
                if (pslverr_i && !e.err) begin
                    $display("error: test %s got a slave error at address %h where none was due",
                             e.name, paddr_i);
                    resp_errors++;
                end else if (!pslverr_i && e.err) begin
                    $display("error: test %s wrote start to a busy lane and saw no slave error",
                             e.name);
                    resp_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_div_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_div_array import div_pkg::*, apb_map_pkg::*; ();

    localparam int MAX_VEC = 64;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // Golden vectors
    string             v_name [MAX_VEC];
    logic [31:0]       v_lane [MAX_VEC];
    logic [31:0]       v_sgn  [MAX_VEC];
    logic [31:0]       v_dvd  [MAX_VEC];
    logic [31:0]       v_dvs  [MAX_VEC];
    logic [31:0]       v_quo  [MAX_VEC];
    logic [31:0]       v_rem  [MAX_VEC];
    logic [31:0]       v_dbz  [MAX_VEC];
    int                nvec = 0;
    int                tb_errors = 0;
    logic              loaded = 1'b0;

    div_array_top dut0 (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    div_checker u_checker (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .prdata_i  (prdata),
        .pready_i  (pready),
        .pslverr_i (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Register map helpers
    // ------------------------------
    function automatic logic [ADDR_W-1:0] reg_addr(input logic [31:0] lane,
                                                  input logic [ADDR_W-1:0] ofs);
        return ADDR_W'(lane) * LANE_STRIDE + ofs;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic start, input logic sgn,
                                              input logic cancel);
        return {29'b0, cancel, sgn, start};
    endfunction

    function automatic logic [31:0] status_word(input logic busy, input logic done,
                                                input logic dbz, input logic sgn);
        return {28'b0, sgn, dbz, done, busy};
    endfunction

    // One setup and access pair, counting wait states
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output int waits);
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            waits++;
            @(posedge clk);
        end
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input string name, input logic [31:0] lane,
                             input logic [ADDR_W-1:0] ofs, input logic [31:0] data,
                             input logic err);
        int waits;
        u_checker.expect_xfer(name, 32'h0, 32'h0, err);
        apb_xfer(1'b1, reg_addr(lane, ofs), data, waits);
    endtask

    task automatic reg_read(input string name, input logic [31:0] lane,
                            input logic [ADDR_W-1:0] ofs, input logic [31:0] exp,
                            input logic [31:0] mask, output int waits);
        u_checker.expect_xfer(name, exp, mask, 1'b0);
        apb_xfer(1'b0, reg_addr(lane, ofs), 32'h0, waits);
    endtask

    // ------------------------------
    // Sequences
    // ------------------------------
    task automatic start_vector(input int k);
        reg_write(v_name[k], v_lane[k], OFS_DIVIDEND, v_dvd[k], 1'b0);
        reg_write(v_name[k], v_lane[k], OFS_DIVISOR, v_dvs[k], 1'b0);
        reg_write(v_name[k], v_lane[k], OFS_CTRL_STATUS, ctrl_word(1'b1, v_sgn[k][0], 1'b0),
                  1'b0);
    endtask

    // Quotient read stalls until the lane has finished
    task automatic check_vector(input int k);
        int waits;
        reg_read(v_name[k], v_lane[k], OFS_QUOTIENT, v_quo[k], '1, waits);
        reg_read(v_name[k], v_lane[k], OFS_REMAINDER, v_rem[k], '1, waits);
        reg_read(v_name[k], v_lane[k], OFS_CTRL_STATUS,
                 status_word(1'b0, 1'b1, v_dbz[k][0], v_sgn[k][0]), '1, waits);
    endtask

    task automatic run_cancel(input int k);
        int waits;
        start_vector(k);
        reg_write(v_name[k], v_lane[k], OFS_CTRL_STATUS, ctrl_word(1'b0, 1'b0, 1'b1), 1'b0);
        // Signed mode bit still shows the last finished operation
        reg_read(v_name[k], v_lane[k], OFS_CTRL_STATUS, 32'h0, 32'hffff_fff7, waits);
        start_vector(k);
        check_vector(k);
    endtask

    task automatic run_busy_start(input int k);
        start_vector(k);
        // Operands were taken at the handshake, so this must not reach the result
        reg_write(v_name[k], v_lane[k], OFS_DIVIDEND, ~v_dvd[k], 1'b0);
        reg_write(v_name[k], v_lane[k], OFS_CTRL_STATUS, ctrl_word(1'b1, v_sgn[k][0], 1'b0),
                  1'b1);
        check_vector(k);
    endtask

    task automatic run_back_to_back(input int first, input int last);
        int waits;
        for (int k = first; k <= last; k++) begin
            start_vector(k);
        end
        reg_read(v_name[last], v_lane[last], OFS_QUOTIENT, v_quo[last], '1, waits);
        if (waits == 0) begin
            $display("error: quotient read right after the last start did not stall");
            tb_errors++;
        end
        for (int k = first; k <= last; k++) begin
            check_vector(k);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] f [7];
        fd   = $fopen("dv/div_golden.txt", "r");
        name = "unnamed";
        if (fd == 0) begin
            $display("error: cannot open dv/div_golden.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() < 2 || line[0] == "#") begin
                    n = 0;
                end else if (line.substr(0, 4) == "test ") begin
                    name = line.substr(5, line.len() - 2);
                end else begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    if (n != 7 || nvec >= MAX_VEC) begin
                        $display("error: golden line not usable: %s", line);
                        tb_errors++;
                    end else begin
                        v_name[nvec] = name;
                        v_lane[nvec] = f[0];
                        v_sgn[nvec]  = f[1];
                        v_dvd[nvec]  = f[2];
                        v_dvs[nvec]  = f[3];
                        v_quo[nvec]  = f[4];
                        v_rem[nvec]  = f[5];
                        v_dbz[nvec]  = f[6];
                        nvec++;
                    end
                end
            end
            $fclose(fd);
        end
        if (nvec == 0) begin
            $display("error: no vectors were read from the golden file");
            tb_errors++;
        end
        loaded = 1'b1;
    endtask

    task automatic report_counts(output int total);
        total = tb_errors + u_checker.data_errors + u_checker.resp_errors;
        $display("error counts: data %0d, response %0d, testbench %0d, total %0d",
                 u_checker.data_errors, u_checker.resp_errors, tb_errors, total);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int i;
        int j;
        int total;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        load_golden();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        i = 0;
        while (i < nvec) begin
            j = i;
            while (j < nvec && v_name[j] == v_name[i]) begin
                j++;
            end
            if (v_name[i] == "back_to_back") begin
                run_back_to_back(i, j - 1);
            end else begin
                for (int k = i; k < j; k++) begin
                    if (v_name[i] == "cancel") begin
                        run_cancel(k);
                    end else if (v_name[i] == "busy_start") begin
                        run_busy_start(k);
                    end else begin
                        start_vector(k);
                        check_vector(k);
                    end
                end
            end
            i = j;
        end
        if (u_checker.pending() != 0) begin
            $display("error: %0d expected transfers never completed", u_checker.pending());
            tb_errors++;
        end
        report_counts(total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        int total;
        wait (loaded);
        repeat (nvec * (ITER_CNT + 12) + 100) @(posedge clk);
        $display("error: timeout, the DUT stopped completing transfers");
        report_counts(total);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/div_pkg.sv
hdl/apb_map_pkg.sv
hdl/div_if.sv
hdl/apb_div_issue.sv
hdl/div_lane.sv
hdl/div_result_collect.sv
hdl/div_array_top.sv
dv/div_checker.sv
dv/tb_div_array.sv

// ==== Makefile ====
# Verilator build and run for the divide array testbench

VERILATOR ?= verilator
TOP       ?= tb_div_array
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) dv/div_golden.txt
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/div_golden.txt ====
# lane signed dividend divisor quotient remainder div_by_zero, all hex
# A line "test <name>" starts a group, and the name selects the sequence
test unsigned
0 0 00000064 00000007 0000000e 00000002 0
1 0 ffffffff 00000010 0fffffff 0000000f 0
2 0 80000000 00000003 2aaaaaaa 00000002 0
3 0 12345678 00001000 00012345 00000678 0
test signed
0 1 ffffff9c 00000007 fffffff2 fffffffe 0
1 1 00000064 fffffff9 fffffff2 00000002 0
2 1 ffffff9c fffffff9 0000000e fffffffe 0
3 1 00000064 00000007 0000000e 00000002 0
0 1 80000000 ffffffff 80000000 00000000 0
test div_zero
1 0 00001234 00000000 ffffffff 00001234 1
2 1 ffffff00 00000000 ffffffff ffffff00 1
test back_to_back
0 0 00000e10 0000003c 0000003c 00000000 0
1 1 fffffc18 00000003 fffffeb3 ffffffff 0
2 0 deadbeef 00010000 0000dead 0000beef 0
3 0 00000005 00000009 00000000 00000005 0
test cancel
1 0 000003e8 0000000a 00000064 00000000 0
test busy_start
2 1 7fffffff fffffffe c0000001 00000001 0
